//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Data word and byte address
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    // One bit per byte lane
    typedef logic [3:0] strobe_t;

    typedef logic [1:0] size_t;

    typedef logic [3:0] cause_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // Machine exception codes for loads and stores
    localparam cause_t CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam cause_t CAUSE_LOAD_FAULT       = 4'd5;
    localparam cause_t CAUSE_STORE_MISALIGNED = 4'd6;
    localparam cause_t CAUSE_STORE_FAULT      = 4'd7;

    // Words in the data memory
    localparam int MEM_WORDS = 256;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

endpackage

`default_nettype wire

//--- source/address_stage.sv
`timescale 1ns/1ps
`default_nettype none

module address_stage (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              op_valid,
    input  wire logic              op_store,
    input  wire lsu_pkg::size_t    op_size,
    input  wire logic              op_unsigned,
    input  wire lsu_pkg::word_t    op_base,
    input  wire lsu_pkg::word_t    op_offset,
    input  wire lsu_pkg::word_t    op_sdata,
    input  wire lsu_pkg::reg_addr_t op_rd,
    input  wire logic              a_ready,
    output logic                   op_ready,
    output logic                   a_valid,
    output logic                   a_store,
    output lsu_pkg::size_t         a_size,
    output logic                   a_unsigned,
    output lsu_pkg::word_t         a_addr,
    output lsu_pkg::strobe_t       a_strobe,
    output lsu_pkg::word_t         a_wdata,
    output lsu_pkg::reg_addr_t     a_rd,
    output logic                   a_fault,
    output lsu_pkg::cause_t        a_cause
);

    logic             accept;
    lsu_pkg::word_t   addr;
    lsu_pkg::strobe_t strobe;
    lsu_pkg::word_t   wdata;
    logic             misaligned;

    // Slot frees up in the same cycle the memory stage takes it
    assign op_ready = !a_valid || a_ready;
    assign accept   = op_valid && op_ready;
    assign addr     = op_base + op_offset;

    always_comb begin
        case (op_size)
            lsu_pkg::SIZE_BYTE: begin
                strobe     = 4'b0001 << addr[1:0];
                wdata      = {4{op_sdata[7:0]}};
                misaligned = 1'b0;
            end
            lsu_pkg::SIZE_HALF: begin
                strobe     = 4'b0011 << addr[1:0];
                wdata      = {2{op_sdata[15:0]}};
                misaligned = addr[0];
            end
            default: begin
                strobe     = 4'b1111;
                wdata      = op_sdata;
                misaligned = |addr[1:0];
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            a_valid <= 1'b0;
        end else if (accept) begin
            a_valid <= 1'b1;
        end else if (a_ready) begin
            a_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            a_store    <= op_store;
            a_size     <= op_size;
            a_unsigned <= op_unsigned;
            a_addr     <= addr;
            a_strobe   <= strobe;
            a_wdata    <= wdata;
            a_rd       <= op_rd;
            a_fault    <= misaligned;
            if (!misaligned) begin
                a_cause <= '0;
            end else if (op_store) begin
                a_cause <= lsu_pkg::CAUSE_STORE_MISALIGNED;
            end else begin
                a_cause <= lsu_pkg::CAUSE_LOAD_MISALIGNED;
            end
        end
    end

    // Held operation must not vanish under back-pressure
    assert property (@(posedge clock) disable iff (!reset)
        a_valid && !a_ready |=> a_valid);

endmodule

`default_nettype wire

//--- source/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               a_valid,
    input  wire logic               a_store,
    input  wire lsu_pkg::size_t     a_size,
    input  wire logic               a_unsigned,
    input  wire lsu_pkg::word_t     a_addr,
    input  wire lsu_pkg::strobe_t   a_strobe,
    input  wire lsu_pkg::word_t     a_wdata,
    input  wire lsu_pkg::reg_addr_t a_rd,
    input  wire logic               a_fault,
    input  wire lsu_pkg::cause_t    a_cause,
    input  wire lsu_pkg::word_t     prdata,
    input  wire logic               pready,
    input  wire logic               pslverr,
    output logic                    a_ready,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output lsu_pkg::word_t          paddr,
    output lsu_pkg::word_t          pwdata,
    output lsu_pkg::strobe_t        pstrb,
    output logic                    m_valid,
    output logic                    m_store,
    output lsu_pkg::size_t          m_size,
    output logic                    m_unsigned,
    output logic [1:0]              m_offset,
    output lsu_pkg::word_t          m_rdata,
    output lsu_pkg::reg_addr_t      m_rd,
    output lsu_pkg::word_t          m_addr,
    output logic                    m_fault,
    output lsu_pkg::cause_t         m_cause
);

    lsu_pkg::apb_state_t state;
    logic                take;
    logic                done;
    logic                hold_store;
    lsu_pkg::size_t      hold_size;
    logic                hold_unsigned;
    lsu_pkg::reg_addr_t  hold_rd;

    assign done = (state == lsu_pkg::ACCESS) && pready;
    // A faulted op waits for IDLE so it never collides with a completing transfer
    assign a_ready = (state == lsu_pkg::IDLE) || (done && !a_fault);
    assign take    = a_valid && a_ready;

    assign psel    = state != lsu_pkg::IDLE;
    assign penable = state == lsu_pkg::ACCESS;
    assign pwrite  = hold_store;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= lsu_pkg::IDLE;
            m_valid <= 1'b0;
        end else begin
            m_valid <= done || (take && a_fault);
            case (state)
                lsu_pkg::IDLE: begin
                    if (take && !a_fault) begin
                        state <= lsu_pkg::SETUP;
                    end
                end
                lsu_pkg::SETUP: state <= lsu_pkg::ACCESS;
                lsu_pkg::ACCESS: begin
                    if (pready) begin
                        state <= take ? lsu_pkg::SETUP : lsu_pkg::IDLE;
                    end
                end
                default: state <= lsu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (take && !a_fault) begin
            hold_store    <= a_store;
            hold_size     <= a_size;
            hold_unsigned <= a_unsigned;
            hold_rd       <= a_rd;
            paddr         <= a_addr;
            pwdata        <= a_wdata;
            pstrb         <= a_store ? a_strobe : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            m_store    <= hold_store;
            m_size     <= hold_size;
            m_unsigned <= hold_unsigned;
            m_rd       <= hold_rd;
            m_addr     <= paddr;
            m_offset   <= paddr[1:0];
            m_rdata    <= prdata;
            m_fault    <= pslverr;
            if (!pslverr) begin
                m_cause <= '0;
            end else begin
                m_cause <= hold_store ? lsu_pkg::CAUSE_STORE_FAULT : lsu_pkg::CAUSE_LOAD_FAULT;
            end
        end else if (take && a_fault) begin
            // Misaligned op skips the bus
            m_store    <= a_store;
            m_size     <= a_size;
            m_unsigned <= a_unsigned;
            m_rd       <= a_rd;
            m_addr     <= a_addr;
            m_offset   <= a_addr[1:0];
            m_rdata    <= '0;
            m_fault    <= 1'b1;
            m_cause    <= a_cause;
        end
    end

    assert property (@(posedge clock) disable iff (!reset) penable |-> psel);

    assert property (@(posedge clock) disable iff (!reset) penable |-> $stable(paddr));

endmodule

`default_nettype wire

//--- source/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               m_valid,
    input  wire logic               m_store,
    input  wire lsu_pkg::size_t     m_size,
    input  wire logic               m_unsigned,
    input  wire logic [1:0]         m_offset,
    input  wire lsu_pkg::word_t     m_rdata,
    input  wire lsu_pkg::reg_addr_t m_rd,
    input  wire lsu_pkg::word_t     m_addr,
    input  wire logic               m_fault,
    input  wire lsu_pkg::cause_t    m_cause,
    output logic                    reg_wren,
    output lsu_pkg::reg_addr_t      reg_waddr,
    output lsu_pkg::word_t          reg_wdata,
    output logic                    exc_valid,
    output lsu_pkg::cause_t         exc_cause,
    output lsu_pkg::word_t          exc_addr
);

    lsu_pkg::word_t shifted;
    lsu_pkg::word_t load_data;

    // Bring the addressed lane down to bit 0
    assign shifted = m_rdata >> {m_offset, 3'b000};

    always_comb begin
        case (m_size)
            lsu_pkg::SIZE_BYTE:
                load_data = m_unsigned ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::SIZE_HALF:
                load_data = m_unsigned ? {16'b0, shifted[15:0]}
                                       : {{16{shifted[15]}}, shifted[15:0]};
            default:
                load_data = m_rdata;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            reg_wren  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            // x0 is hardwired, so no write
            reg_wren  <= m_valid && !m_fault && !m_store && (m_rd != '0);
            exc_valid <= m_valid && m_fault;
        end
    end

    always_ff @(posedge clock) begin
        if (m_valid) begin
            reg_waddr <= m_rd;
            reg_wdata <= load_data;
            exc_cause <= m_cause;
            exc_addr  <= m_addr;
        end
    end

    assert property (@(posedge clock) disable iff (!reset) !(reg_wren && exc_valid));

endmodule

`default_nettype wire

//--- source/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire lsu_pkg::word_t   paddr,
    input  wire lsu_pkg::word_t   pwdata,
    input  wire lsu_pkg::strobe_t pstrb,
    output lsu_pkg::word_t        prdata,
    output logic                  pready,
    output logic                  pslverr
);

    lsu_pkg::word_t                         mem [lsu_pkg::MEM_WORDS];
    logic [$clog2(lsu_pkg::MEM_WORDS)-1:0] index;
    logic                                   in_range;
    logic                                   access;
    logic                                   slow;
    logic                                   waited;

    assign access   = psel && penable;
    assign index    = paddr[$clog2(lsu_pkg::MEM_WORDS)+1:2];
    assign in_range = paddr[31:2] < lsu_pkg::MEM_WORDS;

    // Slow transfers hold PREADY low for their first ACCESS cycle
    assign pready  = !(slow && !waited);
    assign pslverr = access && pready && !in_range;
    assign prdata  = in_range ? mem[index] : '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            slow   <= 1'b0;
            waited <= 1'b0;
        end else if (access) begin
            if (pready) begin
                slow   <= !slow;
                waited <= 1'b0;
            end else begin
                waited <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < lsu_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (access && pready && pwrite && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[index][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lsu_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               op_valid,
    input  wire logic               op_store,
    input  wire lsu_pkg::size_t     op_size,
    input  wire logic               op_unsigned,
    input  wire lsu_pkg::word_t     op_base,
    input  wire lsu_pkg::word_t     op_offset,
    input  wire lsu_pkg::word_t     op_sdata,
    input  wire lsu_pkg::reg_addr_t op_rd,
    output logic                    op_ready,
    output logic                    reg_wren,
    output lsu_pkg::reg_addr_t      reg_waddr,
    output lsu_pkg::word_t          reg_wdata,
    output logic                    exc_valid,
    output lsu_pkg::cause_t         exc_cause,
    output lsu_pkg::word_t          exc_addr
);

    logic a_valid, a_ready, a_store, a_unsigned, a_fault;
    lsu_pkg::size_t     a_size;
    lsu_pkg::word_t     a_addr, a_wdata;
    lsu_pkg::strobe_t   a_strobe;
    lsu_pkg::reg_addr_t a_rd;
    lsu_pkg::cause_t    a_cause;

    logic m_valid, m_store, m_unsigned, m_fault;
    lsu_pkg::size_t     m_size;
    logic [1:0]         m_offset;
    lsu_pkg::word_t     m_rdata, m_addr;
    lsu_pkg::reg_addr_t m_rd;
    lsu_pkg::cause_t    m_cause;

    // APB between the memory stage and the RAM
    logic psel, penable, pwrite, pready, pslverr;
    lsu_pkg::word_t   paddr, pwdata, prdata;
    lsu_pkg::strobe_t pstrb;

    address_stage u_address_stage (
        .clock, .reset, .op_valid, .op_store, .op_size, .op_unsigned, .op_base, .op_offset,
        .op_sdata, .op_rd, .a_ready, .op_ready, .a_valid, .a_store, .a_size, .a_unsigned,
        .a_addr, .a_strobe, .a_wdata, .a_rd, .a_fault, .a_cause
    );

    memory_stage u_memory_stage (
        .clock, .reset, .a_valid, .a_store, .a_size, .a_unsigned, .a_addr, .a_strobe,
        .a_wdata, .a_rd, .a_fault, .a_cause, .prdata, .pready, .pslverr, .a_ready,
        .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .m_valid, .m_store, .m_size,
        .m_unsigned, .m_offset, .m_rdata, .m_rd, .m_addr, .m_fault, .m_cause
    );

    writeback_stage u_writeback_stage (
        .clock, .reset, .m_valid, .m_store, .m_size, .m_unsigned, .m_offset, .m_rdata,
        .m_rd, .m_addr, .m_fault, .m_cause, .reg_wren, .reg_waddr, .reg_wdata,
        .exc_valid, .exc_cause, .exc_addr
    );

    data_memory u_data_memory (
        .clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .prdata, .pready, .pslverr
    );

endmodule

`default_nettype wire

//--- testbench/lsu_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem_tb;

    localparam int MAX_TESTS   = 64;
    localparam int READY_LIMIT = 50;
    localparam int DRAIN_LIMIT = 200;
    localparam int KIND_NONE   = 0;
    localparam int KIND_REG    = 1;
    localparam int KIND_EXC    = 2;

    logic               clock;
    logic               reset;
    logic               op_valid;
    logic               op_store;
    lsu_pkg::size_t     op_size;
    logic               op_unsigned;
    lsu_pkg::word_t     op_base;
    lsu_pkg::word_t     op_offset;
    lsu_pkg::word_t     op_sdata;
    lsu_pkg::reg_addr_t op_rd;
    logic               op_ready;
    logic               reg_wren;
    lsu_pkg::reg_addr_t reg_waddr;
    lsu_pkg::word_t     reg_wdata;
    logic               exc_valid;
    lsu_pkg::cause_t    exc_cause;
    lsu_pkg::word_t     exc_addr;

    // Test table as read from the file
    string              t_name     [MAX_TESTS];
    logic               t_store    [MAX_TESTS];
    lsu_pkg::size_t     t_size     [MAX_TESTS];
    logic               t_unsigned [MAX_TESTS];
    lsu_pkg::word_t     t_base     [MAX_TESTS];
    lsu_pkg::word_t     t_offset   [MAX_TESTS];
    lsu_pkg::word_t     t_sdata    [MAX_TESTS];
    lsu_pkg::reg_addr_t t_rd       [MAX_TESTS];
    int                 t_kind     [MAX_TESTS];
    lsu_pkg::word_t     t_value    [MAX_TESTS];
    int                 num_tests;

    // Results still owed by the DUT, oldest first
    string              exp_name  [$];
    int                 exp_kind  [$];
    lsu_pkg::word_t     exp_value [$];
    lsu_pkg::reg_addr_t exp_rd    [$];
    lsu_pkg::word_t     exp_addr  [$];

    string              cur_name;
    int                 cur_kind;
    lsu_pkg::word_t     cur_value;
    lsu_pkg::reg_addr_t cur_rd;
    lsu_pkg::word_t     cur_addr;
    logic [31:0]        lfsr_state;
    int                 stall_cycles;

    lsu_subsystem u_dut (
        .clock, .reset, .op_valid, .op_store, .op_size, .op_unsigned, .op_base, .op_offset,
        .op_sdata, .op_rd, .op_ready, .reg_wren, .reg_waddr, .reg_wdata, .exc_valid,
        .exc_cause, .exc_addr
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_with_failure(input string why);
        $display("%0s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t expected,
                              input lsu_pkg::word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error in %0s: expected 0x%h, actual 0x%h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input lsu_pkg::reg_addr_t expected,
                             input lsu_pkg::reg_addr_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error in %0s: expected x%0d, actual x%0d",
                                        name, expected, actual));
        end
    endtask

    task automatic check_cause(input string name, input lsu_pkg::cause_t expected,
                               input lsu_pkg::cause_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error in %0s: expected cause %0d, actual cause %0d",
                                        name, expected, actual));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic pick_idle_cycles(output int count);
        count = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            count = (count << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic load_tests();
        int              fd;
        int              fields;
        int              code;
        string           line;
        logic [8*32-1:0] name_text;
        logic [8*8-1:0]  kind_text;
        int              store_bit;
        int              size_val;
        int              unsigned_bit;
        int              rd_val;
        lsu_pkg::word_t  base;
        lsu_pkg::word_t  offset;
        lsu_pkg::word_t  sdata;
        lsu_pkg::word_t  value;
        num_tests = 0;
        fd = $fopen("testbench/lsu_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open testbench/lsu_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %d %d %d %h %h %h %d %s %h", name_text, store_bit,
                                 size_val, unsigned_bit, base, offset, sdata, rd_val,
                                 kind_text, value);
                if (fields != 10 || num_tests >= MAX_TESTS) begin
                    stop_with_failure($sformatf("Cannot use test line: %0s", line));
                end
                t_name[num_tests]     = $sformatf("%0s", name_text);
                t_store[num_tests]    = store_bit[0];
                t_size[num_tests]     = size_val[1:0];
                t_unsigned[num_tests] = unsigned_bit[0];
                t_base[num_tests]     = base;
                t_offset[num_tests]   = offset;
                t_sdata[num_tests]    = sdata;
                t_rd[num_tests]       = rd_val[4:0];
                t_value[num_tests]    = value;
                if (kind_text == "reg") begin
                    t_kind[num_tests] = KIND_REG;
                end else if (kind_text == "exc") begin
                    t_kind[num_tests] = KIND_EXC;
                end else begin
                    t_kind[num_tests] = KIND_NONE;
                end
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_op(input int idx, input int pass);
        int waited;
        waited = 0;
        op_valid    = 1'b1;
        op_store    = t_store[idx];
        op_size     = t_size[idx];
        op_unsigned = t_unsigned[idx];
        op_base     = t_base[idx];
        op_offset   = t_offset[idx];
        op_sdata    = t_sdata[idx];
        op_rd       = t_rd[idx];
        while (!op_ready) begin
            @(negedge clock);
            waited++;
            stall_cycles++;
            if (waited > READY_LIMIT) begin
                stop_with_failure($sformatf("Timed out waiting for op_ready in %0s", t_name[idx]));
            end
        end
        if (t_kind[idx] != KIND_NONE) begin
            exp_name.push_back($sformatf("%0s (pass %0d)", t_name[idx], pass));
            exp_kind.push_back(t_kind[idx]);
            exp_value.push_back(t_value[idx]);
            exp_rd.push_back(t_rd[idx]);
            exp_addr.push_back(t_base[idx] + t_offset[idx]);
        end
        @(negedge clock);
        op_valid = 1'b0;
    endtask

    task automatic run_pass(input int pass, input bit with_gaps);
        int idle;
        for (int idx = 0; idx < num_tests; idx++) begin
            send_op(idx, pass);
            if (with_gaps) begin
                pick_idle_cycles(idle);
                repeat (idle) @(negedge clock);
            end
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_kind.size() != 0) begin
            @(negedge clock);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_with_failure($sformatf("Timed out with %0d results still missing",
                                            exp_kind.size()));
            end
        end
        // Room for a stray late result to show up
        repeat (10) @(negedge clock);
    endtask

    // Outputs are registered, so mid-cycle they are settled
    always @(negedge clock) begin
        if (reset && (reg_wren || exc_valid)) begin
            if (exp_kind.size() == 0) begin
                stop_with_failure("The DUT produced a result that no operation should give");
            end else begin
                cur_name  = exp_name.pop_front();
                cur_kind  = exp_kind.pop_front();
                cur_value = exp_value.pop_front();
                cur_rd    = exp_rd.pop_front();
                cur_addr  = exp_addr.pop_front();
                if (cur_kind == KIND_REG && !reg_wren) begin
                    stop_with_failure($sformatf("%0s raised an exception instead of a load",
                                                cur_name));
                end else if (cur_kind == KIND_EXC && !exc_valid) begin
                    stop_with_failure($sformatf("%0s wrote a register instead of an exception",
                                                cur_name));
                end else if (cur_kind == KIND_REG) begin
                    check_reg(cur_name, cur_rd, reg_waddr);
                    check_word(cur_name, cur_value, reg_wdata);
                end else begin
                    check_cause(cur_name, cur_value[3:0], exc_cause);
                    check_word(cur_name, cur_addr, exc_addr);
                end
            end
        end
    end

    initial begin
        reset        = 1'b0;
        op_valid     = 1'b0;
        op_store     = 1'b0;
        op_size      = lsu_pkg::SIZE_WORD;
        op_unsigned  = 1'b0;
        op_base      = '0;
        op_offset    = '0;
        op_sdata     = '0;
        op_rd        = '0;
        lfsr_state   = 32'h5666_7b63;
        stall_cycles = 0;
        load_tests();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        if (!op_ready) begin
            stop_with_failure("op_ready is low after reset");
        end
        // Random gaps first, then the same list back to back
        run_pass(0, 1'b1);
        stall_cycles = 0;
        run_pass(1, 1'b0);
        if (stall_cycles == 0) begin
            stop_with_failure("Back-to-back operations never saw op_ready drop");
        end
        drain_results();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/lsu_tests.txt
# name store size unsigned base offset sdata rd kind value (hex: base offset sdata value)
# size 0 byte, 1 half, 2 word; kind none, reg or exc; value is load data or exception cause
sw_a        1 2 0 00000100 00000000 11223344 0  none 00000000
sw_b        1 2 0 00000100 00000004 8899aabb 0  none 00000000
lw_a        0 2 0 00000100 00000000 00000000 5  reg  11223344
lw_b        0 2 0 00000100 00000004 00000000 6  reg  8899aabb
lb_off0     0 0 0 00000104 00000000 00000000 7  reg  ffffffbb
lbu_off1    0 0 1 00000104 00000001 00000000 7  reg  000000aa
lb_off2     0 0 0 00000104 00000002 00000000 7  reg  ffffff99
lbu_off3    0 0 1 00000104 00000003 00000000 7  reg  00000088
lbu_off0    0 0 1 00000104 00000000 00000000 7  reg  000000bb
lb_pos      0 0 0 00000100 00000001 00000000 7  reg  00000033
lh_off0     0 1 0 00000104 00000000 00000000 8  reg  ffffaabb
lhu_off2    0 1 1 00000104 00000002 00000000 8  reg  00008899
lh_pos      0 1 0 00000100 00000002 00000000 8  reg  00001122
lhu_off0    0 1 1 00000104 00000000 00000000 8  reg  0000aabb
sw_c        1 2 0 00000200 00000000 cafef00d 0  none 00000000
sb_lane1    1 0 0 00000200 00000001 000000a5 0  none 00000000
sh_upper    1 1 0 00000200 00000002 00001234 0  none 00000000
lw_merged   0 2 0 00000200 00000000 00000000 9  reg  1234a50d
lh_mis      0 1 0 00000100 00000003 00000000 9  exc  00000004
lw_mis      0 2 0 00000100 00000002 00000000 9  exc  00000004
sw_mis      1 2 0 00000200 00000001 deadbeef 0  exc  00000006
sh_mis      1 1 0 00000200 00000003 0000ffff 0  exc  00000006
lw_kept     0 2 0 00000200 00000000 00000000 10 reg  1234a50d
lw_far      0 2 0 00000400 00000000 00000000 11 exc  00000005
sw_far      1 2 0 00000ffc 00000008 12345678 0  exc  00000007
lw_alias    0 2 0 00000000 00000004 00000000 14 reg  00000000
lw_x0       0 2 0 00000100 00000000 00000000 0  none 00000000
lw_after_x0 0 2 0 00000100 00000004 00000000 12 reg  8899aabb
lw_neg      0 2 0 00000210 fffffff0 00000000 13 reg  1234a50d

//--- tb.f
source/lsu_pkg.sv
source/address_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/data_memory.sv
source/lsu_subsystem.sv
testbench/lsu_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module lsu_subsystem_tb -Mdir "$BUILD_DIR" -o lsu_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/lsu_sim" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
    echo "Testbench reported a failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
exit 0
